/* dd_game_video.f */
design/dd_video_pkg.sv
design/dd_char_rom_if.sv
design/dd_cen_gen.sv
design/dd_video_timing.sv
design/dd_char_rom_fetch.sv
design/dd_char_layer.sv
design/dd_palette.sv
design/dd_game_video.sv
sim/dd_game_video_props.sv
sim/dd_game_video_tb.sv

/* design/dd_cen_gen.sv */
// Clock-enable generator
//   cen12 every 4th clk, cen6 every 8th clk
//   both come from one free-running 3-bit counter

`timescale 1ns/100ps
`default_nettype none

module dd_cen_gen (
    input  logic clk,
    input  logic rst_n,
    output logic cen12,
    output logic cen6
);

    logic [2:0] cnt;

    // Strobes are registered, first ones 4 and 8 clocks out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt   <= 3'd0;
            cen12 <= 1'b0;
            cen6  <= 1'b0;
        end else begin
            cnt   <= cnt + 3'd1;
            cen12 <= (cnt[1:0] == 2'd3);
            cen6  <= (cnt == 3'd7);
        end
    end

endmodule

`default_nettype wire

/* design/dd_char_layer.sv */
// Character layer
//   CPU-written tile map, even byte code low, odd byte palette and code high
//   ROM row fetch 16 pixels ahead of drawing
//   8-pixel shifter, colour 0 when the row came late

`timescale 1ns/100ps
`default_nettype none

module dd_char_layer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen6,
    input  logic [8:0]           hcnt,
    input  logic [8:0]           vcnt,
    input  logic [12:0]          cpu_addr,
    input  logic [7:0]           cpu_dout,
    input  logic                 cpu_wrn,
    input  logic                 char_cs,
    dd_char_rom_if.layer         rom,
    output dd_video_pkg::pixel_t pxl
);
    import dd_video_pkg::*;

    logic [7:0] map_lo [1024];
    logic [7:0] map_hi [1024];
    logic [7:0] lo_q;
    logic [7:0] hi_q;
    logic [9:0] map_rd;
    logic       in_map;
    logic       fetch_go;
    logic       row_valid;
    char_row_t  row_buf;
    char_row_t  next_row;
    char_row_t  shift;
    logic [2:0] row_pal;
    logic [2:0] next_pal;
    logic [2:0] cur_pal;

    assign map_rd = {vcnt[7:3], hcnt[7:3]};
    assign in_map = (hcnt[8:3] < TILE_COLS) && (vcnt[8:3] < TILE_ROWS);

    always_ff @(posedge clk) begin
        if (char_cs && !cpu_wrn) begin
            if (cpu_addr[0]) begin
                map_hi[cpu_addr[10:1]] <= cpu_dout;
            end else begin
                map_lo[cpu_addr[10:1]] <= cpu_dout;
            end
        end
        lo_q <= map_lo[map_rd];
        hi_q <= map_hi[map_rd];
    end

    // Tile boundary closes the old fetch, cs drops for one clk before the next
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fetch_go  <= 1'b0;
            rom.cs    <= 1'b0;
            row_valid <= 1'b0;
        end else begin
            fetch_go <= 1'b0;
            if (cen6 && hcnt[2:0] == 3'd0) begin
                rom.cs    <= 1'b0;
                row_valid <= 1'b0;
                fetch_go  <= in_map;
            end else if (fetch_go) begin
                rom.cs <= 1'b1;
            end else if (rom.cs && rom.ok) begin
                rom.cs    <= 1'b0;
                row_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_go) begin
            rom.addr <= '{code: {hi_q[2:0], lo_q}, row: vcnt[2:0]};
            row_pal  <= hi_q[6:4];
        end
        if (rom.cs && rom.ok) begin
            row_buf <= rom.data;
        end
    end

    // Row handed over at the deadline, loaded 14 strobes after its fetch
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            next_row <= '0;
            next_pal <= 3'd0;
            shift    <= '0;
            cur_pal  <= 3'd0;
            pxl      <= '0;
        end else if (cen6) begin
            if (hcnt[2:0] == 3'd0) begin
                next_row <= row_valid ? row_buf : '0;
                next_pal <= row_pal;
            end
            if (hcnt[2:0] == 3'd6) begin
                pxl     <= '{pal: next_pal, color: next_row[31:28]};
                shift   <= {next_row[27:0], 4'd0};
                cur_pal <= next_pal;
            end else begin
                pxl   <= '{pal: cur_pal, color: shift[31:28]};
                shift <= {shift[27:0], 4'd0};
            end
        end
    end

endmodule

`default_nettype wire

/* design/dd_char_rom_fetch.sv */
// Character ROM fetcher
//   maps row reads onto the SDRAM req/ack/data_rdy port
//   three-state FSM, one request outstanding
//   no new request while the ROM is downloading

`timescale 1ns/100ps
`default_nettype none

module dd_char_rom_fetch (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               downloading,
    dd_char_rom_if.fetcher     rom,
    output logic               sdram_req,
    output logic [21:0]        sdram_addr,
    input  logic               sdram_ack,
    input  logic               data_rdy,
    input  logic [31:0]        data_read
);
    import dd_video_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACK,
        ST_DATA
    } state_t;

    state_t     state;
    char_addr_t req_addr;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            sdram_req <= 1'b0;
            rom.ok    <= 1'b0;
        end else begin
            rom.ok <= 1'b0;
            case (state)
                ST_IDLE: begin
                    // ok still high means cs belongs to the finished read
                    if (rom.cs && !rom.ok && !downloading) begin
                        sdram_req  <= 1'b1;
                        sdram_addr <= CHAR_OFFSET + 22'(rom.addr);
                        req_addr   <= rom.addr;
                        state      <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (sdram_ack) begin
                        sdram_req <= 1'b0;
                        state     <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (data_rdy) begin
                        state <= ST_IDLE;
                        // Stale answer when the layer gave up or moved on
                        if (rom.cs && rom.addr == req_addr) begin
                            rom.data <= data_read;
                            rom.ok   <= 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* design/dd_char_rom_if.sv */
// Character ROM port between the layer and the SDRAM fetcher
//   layer side drives addr and cs
//   fetcher side returns data with a one-clock ok

`timescale 1ns/100ps
`default_nettype none

interface dd_char_rom_if;
    import dd_video_pkg::*;

    char_addr_t addr;
    logic       cs;
    char_row_t  data;
    logic       ok;

    modport layer (
        output addr,
        output cs,
        input  data,
        input  ok
    );

    modport fetcher (
        input  addr,
        input  cs,
        output data,
        output ok
    );

endinterface

`default_nettype wire

/* design/dd_game_video.sv */
// Character video top level
//   clock enables, video timing, character layer and palette
//   character ROM fetcher on the SDRAM port
//   sync and blanking delay line matched to the pixel pipeline

`timescale 1ns/100ps
`default_nettype none

module dd_game_video (
    input  logic        clk,
    input  logic        rst_n,
    output logic        pxl_cen,
    output logic        pxl2_cen,
    output logic        HS,
    output logic        VS,
    output logic        LHBL_dly,
    output logic        LVBL_dly,
    output logic [3:0]  red,
    output logic [3:0]  green,
    output logic [3:0]  blue,
    input  logic [12:0] cpu_addr,
    input  logic [7:0]  cpu_dout,
    input  logic        cpu_wrn,
    input  logic        char_cs,
    input  logic        pal_cs,
    input  logic        downloading,
    output logic        sdram_req,
    output logic [21:0] sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  logic [31:0] data_read
);
    import dd_video_pkg::*;

    logic       cen12;
    logic       cen6;
    logic [8:0] hcnt;
    logic [8:0] vcnt;
    logic       tm_hs;
    logic       tm_vs;
    logic       tm_hbl;
    logic       tm_vbl;
    pixel_t     pxl;
    rgb_t       rgb;
    logic       pal_blank;
    // Each stage holds {HS, VS, HBL, VBL}
    logic [3:0] sync_dly [PIPE_DELAY];

    dd_char_rom_if char_rom ();

    assign pxl_cen  = cen6;
    assign pxl2_cen = cen12;

    dd_cen_gen u_cen (
        .clk   (clk),
        .rst_n (rst_n),
        .cen12 (cen12),
        .cen6  (cen6)
    );

    dd_video_timing u_timing (
        .clk   (clk),
        .rst_n (rst_n),
        .cen6  (cen6),
        .hcnt  (hcnt),
        .vcnt  (vcnt),
        .HS    (tm_hs),
        .VS    (tm_vs),
        .HBL   (tm_hbl),
        .VBL   (tm_vbl)
    );

    dd_char_layer u_char (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen6     (cen6),
        .hcnt     (hcnt),
        .vcnt     (vcnt),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .cpu_wrn  (cpu_wrn),
        .char_cs  (char_cs),
        .rom      (char_rom.layer),
        .pxl      (pxl)
    );

    dd_char_rom_fetch u_fetch (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .rom         (char_rom.fetcher),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read)
    );

    dd_palette u_pal (
        .clk      (clk),
        .rst_n    (rst_n),
        .cen6     (cen6),
        .pxl      (pxl),
        .blank    (pal_blank),
        .cpu_addr (cpu_addr),
        .cpu_dout (cpu_dout),
        .cpu_wrn  (cpu_wrn),
        .pal_cs   (pal_cs),
        .rgb      (rgb)
    );

    // Stage i lags the counters by i+1 strobes
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < PIPE_DELAY; i++) begin
                sync_dly[i] <= 4'b0011;
            end
        end else if (cen6) begin
            sync_dly[0] <= {tm_hs, tm_vs, tm_hbl, tm_vbl};
            for (int i = 1; i < PIPE_DELAY; i++) begin
                sync_dly[i] <= sync_dly[i-1];
            end
        end
    end

    // Palette register adds the last strobe of delay
    assign pal_blank = sync_dly[PIPE_DELAY-2][1] | sync_dly[PIPE_DELAY-2][0];

    assign HS       = sync_dly[PIPE_DELAY-1][3];
    assign VS       = sync_dly[PIPE_DELAY-1][2];
    assign LHBL_dly = ~sync_dly[PIPE_DELAY-1][1];
    assign LVBL_dly = ~sync_dly[PIPE_DELAY-1][0];

    assign red   = rgb.r;
    assign green = rgb.g;
    assign blue  = rgb.b;

endmodule

`default_nettype wire

/* design/dd_palette.sv */
// Palette
//   128 entries, even byte red and green, odd byte blue
//   RGB output registered on the pixel strobe, black while blanking

`timescale 1ns/100ps
`default_nettype none

module dd_palette (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 cen6,
    input  dd_video_pkg::pixel_t pxl,
    input  logic                 blank,
    input  logic [12:0]          cpu_addr,
    input  logic [7:0]           cpu_dout,
    input  logic                 cpu_wrn,
    input  logic                 pal_cs,
    output dd_video_pkg::rgb_t   rgb
);

    logic [7:0] pal_rg [128];
    logic [3:0] pal_b  [128];
    logic [6:0] idx;

    assign idx = pxl;

    always_ff @(posedge clk) begin
        if (pal_cs && !cpu_wrn) begin
            if (cpu_addr[0]) begin
                pal_b[cpu_addr[7:1]] <= cpu_dout[3:0];
            end else begin
                pal_rg[cpu_addr[7:1]] <= cpu_dout;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rgb <= '0;
        end else if (cen6) begin
            rgb <= blank ? '0 : {pal_rg[idx], pal_b[idx]};
        end
    end

endmodule

`default_nettype wire

/* design/dd_video_pkg.sv */
// Shared definitions for the character video path
//   video geometry and sync windows
//   output pipeline depth and tile map size
//   character ROM location in SDRAM
//   pixel, colour, ROM row and ROM address types

`default_nettype none

package dd_video_pkg;

    // Horizontal timing in pixel strobes
    localparam int H_TOTAL   = 384;
    localparam int H_VISIBLE = 256;
    localparam int HS_START  = 288;
    localparam int HS_END    = 320;

    // Vertical timing in lines
    localparam int V_TOTAL   = 264;
    localparam int V_VISIBLE = 224;
    localparam int VS_START  = 240;
    localparam int VS_END    = 244;

    // Pixel strobes from the counters to the RGB output
    localparam int PIPE_DELAY = 16;

    // Character rows start at this SDRAM word address
    localparam logic [21:0] CHAR_OFFSET = 22'h28000;

    localparam int TILE_COLS = 32;
    localparam int TILE_ROWS = 28;

    typedef struct packed {
        logic [2:0] pal;
        logic [3:0] color;
    } pixel_t;

    typedef struct packed {
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } rgb_t;

    // Eight 4-bit pixels, leftmost pixel in the top nibble
    typedef logic [31:0] char_row_t;

    typedef struct packed {
        logic [10:0] code;
        logic [2:0]  row;
    } char_addr_t;

endpackage

`default_nettype wire

/* design/dd_video_timing.sv */
// Video timing generator
//   pixel and line counters advanced by the pixel strobe
//   sync and blanking decoded from the package windows

`timescale 1ns/100ps
`default_nettype none

module dd_video_timing (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen6,
    output logic [8:0] hcnt,
    output logic [8:0] vcnt,
    output logic       HS,
    output logic       VS,
    output logic       HBL,
    output logic       VBL
);
    import dd_video_pkg::*;

    logic [8:0] hnext;
    logic [8:0] vnext;

    always_comb begin
        hnext = hcnt + 9'd1;
        vnext = vcnt;
        if (hcnt == 9'(H_TOTAL - 1)) begin
            hnext = 9'd0;
            if (vcnt == 9'(V_TOTAL - 1)) begin
                vnext = 9'd0;
            end else begin
                vnext = vcnt + 9'd1;
            end
        end
    end

    // Decode from the next count so the flags line up with the counters
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hcnt <= 9'd0;
            vcnt <= 9'd0;
            HS   <= 1'b0;
            VS   <= 1'b0;
            HBL  <= 1'b1;
            VBL  <= 1'b1;
        end else if (cen6) begin
            hcnt <= hnext;
            vcnt <= vnext;
            HBL  <= (hnext >= 9'(H_VISIBLE));
            VBL  <= (vnext >= 9'(V_VISIBLE));
            HS   <= (hnext >= 9'(HS_START)) && (hnext < 9'(HS_END));
            VS   <= (vnext >= 9'(VS_START)) && (vnext < 9'(VS_END));
        end
    end

endmodule

`default_nettype wire

/* sim/dd_game_video_props.sv */
// SDRAM handshake assertions for the character ROM fetcher
//   request held until ack, address stable while requesting
//   ok only after the data of a pending request

`timescale 1ns/100ps
`default_nettype none

module dd_game_video_props (
    input logic        clk,
    input logic        rst_n,
    input logic        sdram_req,
    input logic [21:0] sdram_addr,
    input logic        sdram_ack,
    input logic        data_rdy,
    input logic        ok
);

    logic pending;

    // Set from the request, cleared by the data
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (sdram_req) begin
            pending <= 1'b1;
        end else if (data_rdy) begin
            pending <= 1'b0;
        end
    end

    req_held: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> sdram_req)
        else $error("sdram_req dropped before sdram_ack");

    addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        sdram_req && !sdram_ack |=> $stable(sdram_addr))
        else $error("sdram_addr changed while sdram_req was high");

    ok_pending: assert property (@(posedge clk) disable iff (!rst_n)
        ok |-> $past(pending && data_rdy))
        else $error("ok without a pending SDRAM request");

endmodule

`default_nettype wire

/* sim/dd_game_video_tb.sv */
// Testbench for the character video top level
//   clock, reset and random CPU writes to the tile map and palette
//   SDRAM responder with random ack and data delays
//   reference model of the tile map, ROM contents and palette
//   frame timing, SDRAM address and pixel checks

`timescale 1ns/100ps
`default_nettype none

module dd_game_video_tb;
    import dd_video_pkg::*;

    localparam int WAIT_LIMIT = 2 * H_TOTAL * V_TOTAL * 8;

    logic        clk;
    logic        rst_n;
    logic        pxl_cen;
    logic        pxl2_cen;
    logic        HS;
    logic        VS;
    logic        LHBL_dly;
    logic        LVBL_dly;
    logic [3:0]  red;
    logic [3:0]  green;
    logic [3:0]  blue;
    logic [12:0] cpu_addr;
    logic [7:0]  cpu_dout;
    logic        cpu_wrn;
    logic        char_cs;
    logic        pal_cs;
    logic        downloading;
    logic        sdram_req;
    logic [21:0] sdram_addr;
    logic        sdram_ack;
    logic        data_rdy;
    logic [31:0] data_read;
    rgb_t        rgb_out;

    integer      seed;

    // Reference copies of the CPU-visible memories
    logic [7:0]  map_lo_m [1024];
    logic [7:0]  map_hi_m [1024];
    logic [7:0]  pal_rg_m [128];
    logic [3:0]  pal_b_m  [128];

    // Frame monitor state
    logic        mon_on = 1'b0;
    logic        hb_q = 1'b0;
    logic        vb_q = 1'b0;
    logic        hs_q = 1'b0;
    logic        vs_q = 1'b0;
    logic        h_seen = 1'b0;
    logic        v_seen = 1'b0;
    logic        frame_dl = 1'b0;
    int          hstrobes = 0;
    int          hvis = 0;
    int          hb_cnt = 0;
    int          vlines = 0;
    int          vvis = 0;
    int          vb_lines = 0;
    int          pix_col = 0;
    int          pix_line = 0;
    int          frames = 0;
    int          pix_checked = 0;
    int          fetch_idx = 0;

    dd_game_video UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .pxl_cen     (pxl_cen),
        .pxl2_cen    (pxl2_cen),
        .HS          (HS),
        .VS          (VS),
        .LHBL_dly    (LHBL_dly),
        .LVBL_dly    (LVBL_dly),
        .red         (red),
        .green       (green),
        .blue        (blue),
        .cpu_addr    (cpu_addr),
        .cpu_dout    (cpu_dout),
        .cpu_wrn     (cpu_wrn),
        .char_cs     (char_cs),
        .pal_cs      (pal_cs),
        .downloading (downloading),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .sdram_ack   (sdram_ack),
        .data_rdy    (data_rdy),
        .data_read   (data_read)
    );

    bind dd_char_rom_fetch dd_game_video_props u_props (
        .clk        (clk),
        .rst_n      (rst_n),
        .sdram_req  (sdram_req),
        .sdram_addr (sdram_addr),
        .sdram_ack  (sdram_ack),
        .data_rdy   (data_rdy),
        .ok         (rom.ok)
    );

    assign rgb_out = '{r: red, g: green, b: blue};

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_on_failure(input string what);
        $display("%s", what);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            stop_on_failure($sformatf("Error: %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_sdram_addr(input logic [21:0] got, input logic [21:0] exp);
        if (got !== exp) begin
            stop_on_failure($sformatf("Error: sdram_addr got %h expected %h", got, exp));
        end
    endtask

    task automatic check_rgb(input rgb_t got, input rgb_t exp, input int col, input int ln);
        if (got !== exp) begin
            stop_on_failure($sformatf("Error: rgb got %h expected %h at line %0d column %0d",
                                      got, exp, ln, col));
        end
    endtask

    // ROM word stored at a given SDRAM word address
    function automatic logic [31:0] rom_word(input logic [21:0] addr);
        logic [31:0] w;
        w = {10'd0, addr};
        return w ^ (w << 18);
    endfunction

    function automatic logic [21:0] row_address(input int ln, input int tile);
        int         idx;
        char_addr_t a;
        idx    = (ln / 8) * TILE_COLS + tile;
        a.code = {map_hi_m[idx][2:0], map_lo_m[idx]};
        a.row  = 3'(ln % 8);
        return CHAR_OFFSET + 22'(a);
    endfunction

    function automatic rgb_t expected_rgb(input int col, input int ln, input logic dl);
        int          idx;
        logic [31:0] w;
        logic [3:0]  color;
        logic [6:0]  entry;
        idx   = (ln / 8) * TILE_COLS + col / 8;
        w     = rom_word(row_address(ln, col / 8));
        // Leftmost pixel sits in the top nibble
        color = dl ? 4'd0 : 4'(w >> (28 - 4 * (col % 8)));
        entry = {map_hi_m[idx][6:4], color};
        return '{r: pal_rg_m[entry][7:4], g: pal_rg_m[entry][3:0], b: pal_b_m[entry]};
    endfunction

    task automatic write_cpu(input logic to_pal, input logic [12:0] addr, input logic [7:0] data);
        @(posedge clk);
        cpu_addr <= addr;
        cpu_dout <= data;
        cpu_wrn  <= 1'b0;
        char_cs  <= !to_pal;
        pal_cs   <= to_pal;
    endtask

    task automatic load_random_contents();
        logic [7:0] b;
        for (int i = 0; i < 1024; i++) begin
            b = 8'($random(seed));
            map_lo_m[i] = b;
            write_cpu(1'b0, 13'(2 * i), b);
            b = 8'($random(seed));
            map_hi_m[i] = b;
            write_cpu(1'b0, 13'(2 * i + 1), b);
        end
        for (int i = 0; i < 128; i++) begin
            b = 8'($random(seed));
            pal_rg_m[i] = b;
            write_cpu(1'b1, 13'(2 * i), b);
            b = 8'($random(seed));
            pal_b_m[i] = b[3:0];
            write_cpu(1'b1, 13'(2 * i + 1), b);
        end
        @(posedge clk);
        cpu_wrn <= 1'b1;
        char_cs <= 1'b0;
        pal_cs  <= 1'b0;
    endtask

    // Clock counts from the reset release edge
    task automatic check_strobes();
        int last12;
        int last6;
        last12 = 0;
        last6  = 0;
        for (int k = 1; k <= 64; k++) begin
            @(posedge clk);
            @(negedge clk);
            if (pxl2_cen) begin
                check_count("pxl2_cen interval", k - last12, 4);
                last12 = k;
            end
            if (pxl_cen) begin
                check_count("pxl_cen interval", k - last6, 8);
                last6 = k;
            end
        end
        check_count("last pxl2_cen clock", last12, 64);
        check_count("last pxl_cen clock", last6, 64);
    endtask

    task automatic wait_vblank_level(input logic level);
        int n;
        n = 0;
        while (LVBL_dly !== level) begin
            @(posedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                stop_on_failure("Timeout waiting for a vertical blanking edge");
            end
        end
    endtask

    task automatic wait_frames(input int count);
        int n;
        n = 0;
        while (frames < count) begin
            @(posedge clk);
            n++;
            if (n > count * WAIT_LIMIT) begin
                stop_on_failure("Timeout waiting for checked frames to start");
            end
        end
    endtask

    // SDRAM responder, one request at a time
    initial begin : sdram_model
        logic [21:0] addr;
        int          d;
        sdram_ack = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(posedge clk);
            if (sdram_req === 1'b1) begin
                if (downloading) begin
                    stop_on_failure("A new sdram_req started while downloading was high");
                end
                addr = sdram_addr;
                check_sdram_addr(addr, row_address((fetch_idx / TILE_COLS) % V_VISIBLE,
                                                   fetch_idx % TILE_COLS));
                d = 1 + ({$random(seed)} % 6);
                repeat (d - 1) @(posedge clk);
                sdram_ack <= 1'b1;
                @(posedge clk);
                sdram_ack <= 1'b0;
                d = 1 + ({$random(seed)} % 6);
                repeat (d - 1) @(posedge clk);
                data_rdy  <= 1'b1;
                data_read <= rom_word(addr);
                @(posedge clk);
                data_rdy <= 1'b0;
                fetch_idx++;
            end
        end
    end

    // Outputs hold for a whole strobe, sampled mid-period
    always @(negedge clk) begin
        if (pxl_cen) begin
            if (mon_on) begin
                if (LHBL_dly && !hb_q) begin
                    if (h_seen) begin
                        check_count("strobes per line", hstrobes, H_TOTAL);
                    end
                    h_seen   = 1'b1;
                    hstrobes = 1;
                    hvis     = 1;
                    pix_col  = 0;
                    if (LVBL_dly && !vb_q) begin
                        if (v_seen) begin
                            check_count("lines per frame", vlines, V_TOTAL);
                        end
                        v_seen   = 1'b1;
                        vlines   = 1;
                        vvis     = 1;
                        pix_line = 0;
                        frames++;
                        frame_dl = downloading;
                    end else begin
                        vlines++;
                        if (LVBL_dly) begin
                            vvis++;
                            pix_line++;
                        end
                    end
                    if (!LVBL_dly && vb_q) begin
                        if (v_seen) begin
                            check_count("LVBL_dly high lines", vvis, V_VISIBLE);
                        end
                        vb_lines = 0;
                    end else begin
                        vb_lines++;
                    end
                end else begin
                    hstrobes++;
                    if (LHBL_dly) begin
                        hvis++;
                        pix_col++;
                    end
                end
                if (!LHBL_dly && hb_q) begin
                    if (h_seen) begin
                        check_count("LHBL_dly high strobes", hvis, H_VISIBLE);
                    end
                    hb_cnt = 0;
                end else begin
                    hb_cnt++;
                end
                if (h_seen && HS != hs_q) begin
                    check_count(HS ? "HS rise offset" : "HS fall offset", hb_cnt,
                                HS ? HS_START - H_VISIBLE : HS_END - H_VISIBLE);
                end
                if (v_seen && VS != vs_q) begin
                    check_count(VS ? "VS rise offset" : "VS fall offset", vb_lines,
                                VS ? VS_START - V_VISIBLE : VS_END - V_VISIBLE);
                end
                if (v_seen) begin
                    if (LHBL_dly && LVBL_dly) begin
                        check_rgb(rgb_out, expected_rgb(pix_col, pix_line, frame_dl),
                                  pix_col, pix_line);
                        pix_checked++;
                    end else begin
                        check_rgb(rgb_out, '0, pix_col, pix_line);
                    end
                end
            end
            hb_q = LHBL_dly;
            vb_q = LVBL_dly;
            hs_q = HS;
            vs_q = VS;
        end
    end

    initial begin
        seed        = 3139;
        rst_n       = 1'b0;
        cpu_addr    = '0;
        cpu_dout    = '0;
        cpu_wrn     = 1'b1;
        char_cs     = 1'b0;
        pal_cs      = 1'b0;
        // Held high so no fetch runs before the tile map is loaded
        downloading = 1'b1;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        check_strobes();
        load_random_contents();

        // Fetching starts with the first line of frame 1
        wait_vblank_level(1'b1);
        wait_vblank_level(1'b0);
        downloading <= 1'b0;
        mon_on = 1'b1;

        // Two normal frames, then one with the ROM held off
        wait_frames(2);
        wait_vblank_level(1'b0);
        downloading <= 1'b1;
        wait_vblank_level(1'b1);
        wait_vblank_level(1'b0);
        downloading <= 1'b0;

        check_count("visible pixels checked", pix_checked, 3 * H_VISIBLE * V_VISIBLE);
        check_count("SDRAM reads", fetch_idx, 2 * V_VISIBLE * TILE_COLS);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire
